// File: hw/pe_pkg.sv
package pe_pkg;

	// default datapath widths
	localparam int DEF_WI_T = 14;	// transformed input element
	localparam int DEF_WK_T = 10;	// transformed weight element
	localparam int DEF_WM_O = 20;	// raw product kept
	localparam int DEF_WO_T = 12;	// cut product and output transform
	localparam int DEF_WB   = 7;	// conv bias
	localparam int DEF_WFR  = 13;	// three-frame sum
	localparam int DEF_WCH  = 14;	// channel accumulation
	localparam int DEF_WO   = 12;	// final output

	// tile geometry of F(2x2, 3x3)
	localparam int TILE_ELEMS = 16;	// 4x4 input tile
	localparam int OUT_ELEMS  = 4;	// 2x2 result

	// pipeline latencies in clock cycles
	localparam int TILE_LAT   = 4;
	localparam int ACC_LAT    = 2;
	localparam int POOL_LAT   = 4;
	localparam int PE_LATENCY = TILE_LAT + ACC_LAT + POOL_LAT;

	// across-frame pooling zeroes frame 2
	typedef enum logic {
		POOL_ACROSS_FRAMES = 1'b0,
		POOL_PER_FRAME     = 1'b1
	} pool_mode_e;

	// which 12-bit window of the channel sum is kept
	typedef enum logic {
		FIX_SHIFT2 = 1'b0,
		FIX_SHIFT1 = 1'b1
	} out_fix_e;

endpackage

// File: hw/winograd_tile_path.sv
`timescale 1ns/1ps

module winograd_tile_path #(
	parameter int WI_T = pe_pkg::DEF_WI_T,
	parameter int WK_T = pe_pkg::DEF_WK_T,
	parameter int WM_O = pe_pkg::DEF_WM_O,
	parameter int WO_T = pe_pkg::DEF_WO_T
) (
	input  logic                                clk,
	input  logic [pe_pkg::TILE_ELEMS*WI_T-1:0]  frame,
	input  logic [pe_pkg::TILE_ELEMS*WK_T-1:0]  weight,
	output logic [pe_pkg::OUT_ELEMS*WO_T-1:0]   tile_out
);
	import pe_pkg::*;

	localparam int DIM = 4;	// rows and columns of the input tile

	logic signed [WI_T-1:0]      frame_el [TILE_ELEMS];
	logic signed [WK_T-1:0]      weight_el [TILE_ELEMS];
	logic signed [WI_T+WK_T-1:0] full_prod [TILE_ELEMS];
	logic signed [WM_O-1:0]      prod [TILE_ELEMS];
	logic signed [WO_T-1:0]      cut [TILE_ELEMS];
	logic signed [WO_T-1:0]      row_t [2*DIM];	// A' * M as two rows of four
	logic signed [WO_T-1:0]      res [OUT_ELEMS];

	// element 0 sits in the top slice
	for (genvar i = 0; i < TILE_ELEMS; i++)
	begin : g_unpack
		assign frame_el[i] = frame[(TILE_ELEMS-i)*WI_T-1 -: WI_T];
		assign weight_el[i] = weight[(TILE_ELEMS-i)*WK_T-1 -: WK_T];
	end

	always_comb
	begin
		for (int i = 0; i < TILE_ELEMS; i++)
			full_prod[i] = frame_el[i] * weight_el[i];
	end

	// stages 1 and 2 form the element-wise product and keep its upper WO_T of WM_O bits
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < TILE_ELEMS; i++)
		begin
			prod[i] <= full_prod[i][WM_O-1:0];
			cut[i] <= prod[i][WM_O-1 -: WO_T];
		end
	end

	// stage 3 applies the left transform with rows [1 1 1 0] and [0 1 -1 -1]
	always_ff @(posedge clk)
	begin
		for (int c = 0; c < DIM; c++)
		begin
			row_t[c] <= cut[c] + cut[DIM+c] + cut[2*DIM+c];
			row_t[DIM+c] <= cut[DIM+c] - cut[2*DIM+c] - cut[3*DIM+c];
		end
	end

	// stage 4 applies the right transform over the columns of each row
	always_ff @(posedge clk)
	begin
		for (int r = 0; r < 2; r++)
		begin
			res[2*r] <= row_t[DIM*r] + row_t[DIM*r+1] + row_t[DIM*r+2];
			res[2*r+1] <= row_t[DIM*r+1] - row_t[DIM*r+2] - row_t[DIM*r+3];
		end
	end

	for (genvar j = 0; j < OUT_ELEMS; j++)
	begin : g_pack
		assign tile_out[(OUT_ELEMS-j)*WO_T-1 -: WO_T] = res[j];	// (1,1) on top
	end

endmodule

// File: hw/control_delay.sv
`timescale 1ns/1ps

module control_delay #(
	parameter int WB = pe_pkg::DEF_WB
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               chan_start,
	input  logic signed [WB-1:0] conv_bias,
	input  pe_pkg::pool_mode_e pool_mode,
	input  pe_pkg::out_fix_e   out_fix,
	output logic               chan_start_acc,
	output logic signed [WB-1:0] bias_acc,
	output pe_pkg::pool_mode_e pool_mode_pool,
	output pe_pkg::out_fix_e   out_fix_pool
);
	import pe_pkg::*;

	localparam int ACC_DLY  = TILE_LAT + 1;	// consumed by the channel sum register
	localparam int MODE_DLY = TILE_LAT + ACC_LAT + POOL_LAT - 2;
	localparam int FIX_DLY  = MODE_DLY + 1;	// one stage behind the mode select

	logic [ACC_DLY-1:0]    start_sr;
	logic signed [WB-1:0]  bias_sr [ACC_DLY];
	pool_mode_e            pool_sr [MODE_DLY];
	out_fix_e              fix_sr [FIX_DLY];

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			start_sr <= '0;
			for (int i = 0; i < ACC_DLY; i++)
				bias_sr[i] <= '0;
			for (int i = 0; i < MODE_DLY; i++)
				pool_sr[i] <= POOL_ACROSS_FRAMES;
			for (int i = 0; i < FIX_DLY; i++)
				fix_sr[i] <= FIX_SHIFT2;
		end
		else
		begin
			start_sr <= {start_sr[ACC_DLY-2:0], chan_start};
			bias_sr[0] <= conv_bias;
			pool_sr[0] <= pool_mode;
			fix_sr[0] <= out_fix;
			for (int i = 1; i < ACC_DLY; i++)
				bias_sr[i] <= bias_sr[i-1];
			for (int i = 1; i < MODE_DLY; i++)
				pool_sr[i] <= pool_sr[i-1];
			for (int i = 1; i < FIX_DLY; i++)
				fix_sr[i] <= fix_sr[i-1];
		end
	end

	assign chan_start_acc = start_sr[ACC_DLY-1];
	assign bias_acc = bias_sr[ACC_DLY-1];
	assign pool_mode_pool = pool_sr[MODE_DLY-1];
	assign out_fix_pool = fix_sr[FIX_DLY-1];

	// channel start must meet its data at the accumulator once the line is filled
	a_start_align: assert property (@(posedge clk) disable iff (!reset)
		$past(reset, ACC_DLY) |-> chan_start_acc == $past(chan_start, ACC_DLY))
		else $error("channel start lost alignment with its data");

endmodule

// File: hw/channel_accumulator.sv
`timescale 1ns/1ps

module channel_accumulator #(
	parameter int WO_T = pe_pkg::DEF_WO_T,
	parameter int WFR  = pe_pkg::DEF_WFR,
	parameter int WCH  = pe_pkg::DEF_WCH,
	parameter int WB   = pe_pkg::DEF_WB
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [pe_pkg::OUT_ELEMS*WO_T-1:0] tile_a,
	input  logic [pe_pkg::OUT_ELEMS*WO_T-1:0] tile_b,
	input  logic [pe_pkg::OUT_ELEMS*WO_T-1:0] tile_c,
	input  logic                              chan_start_acc,
	input  logic signed [WB-1:0]              bias_acc,
	output logic [pe_pkg::OUT_ELEMS*WCH-1:0]  chan_sum
);
	import pe_pkg::*;

	logic signed [WO_T-1:0] a_el [OUT_ELEMS];
	logic signed [WO_T-1:0] b_el [OUT_ELEMS];
	logic signed [WO_T-1:0] c_el [OUT_ELEMS];
	logic signed [WFR-1:0]  fsum [OUT_ELEMS];
	logic signed [WCH-1:0]  csum [OUT_ELEMS];

	for (genvar j = 0; j < OUT_ELEMS; j++)
	begin : g_elem
		assign a_el[j] = tile_a[(OUT_ELEMS-j)*WO_T-1 -: WO_T];
		assign b_el[j] = tile_b[(OUT_ELEMS-j)*WO_T-1 -: WO_T];
		assign c_el[j] = tile_c[(OUT_ELEMS-j)*WO_T-1 -: WO_T];
		assign chan_sum[(OUT_ELEMS-j)*WCH-1 -: WCH] = csum[j];
	end

	// three products of one output frame
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int j = 0; j < OUT_ELEMS; j++)
				fsum[j] <= '0;
		end
		else
		begin
			for (int j = 0; j < OUT_ELEMS; j++)
				fsum[j] <= WFR'(a_el[j]) + WFR'(b_el[j]) + WFR'(c_el[j]);
		end
	end

	// first channel loads the bias and later ones add on
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int j = 0; j < OUT_ELEMS; j++)
				csum[j] <= '0;
		end
		else if (chan_start_acc)
		begin
			for (int j = 0; j < OUT_ELEMS; j++)
				csum[j] <= WCH'(fsum[j]) + WCH'(bias_acc);
		end
		else
		begin
			for (int j = 0; j < OUT_ELEMS; j++)
				csum[j] <= csum[j] + WCH'(fsum[j]);	// wraps at WCH
		end
	end

	// an unknown start would corrupt every later channel of the pixel
	a_start_known: assert property (@(posedge clk) disable iff (!reset)
		!$isunknown(chan_start_acc))
		else $error("channel start unknown at the accumulator");

endmodule

// File: hw/relu_pool_unit.sv
`timescale 1ns/1ps

module relu_pool_unit #(
	parameter int WCH = pe_pkg::DEF_WCH,
	parameter int WO  = pe_pkg::DEF_WO
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [pe_pkg::OUT_ELEMS*WCH-1:0] chan_sum1,
	input  logic [pe_pkg::OUT_ELEMS*WCH-1:0] chan_sum2,
	input  pe_pkg::pool_mode_e               pool_mode_pool,
	input  pe_pkg::out_fix_e                 out_fix_pool,
	output logic signed [WO-1:0]             ofmp_frame1,
	output logic signed [WO-1:0]             ofmp_frame2
);
	import pe_pkg::*;

	logic signed [WCH-1:0] cs [2][OUT_ELEMS];	// [frame][element]
	logic signed [WCH-1:0] relu [2][OUT_ELEMS];
	logic signed [WCH-1:0] pair_top [2];	// max of (1,1) and (1,2)
	logic signed [WCH-1:0] pair_bot [2];	// max of (2,1) and (2,2)
	logic signed [WCH-1:0] pool_fr [2];
	logic signed [WCH-1:0] pooled1;
	logic signed [WCH-1:0] pooled2;
	logic                  relu_neg;

	function automatic logic signed [WCH-1:0] smax(
		input logic signed [WCH-1:0] a,
		input logic signed [WCH-1:0] b
	);
		return (a > b) ? a : b;
	endfunction

	for (genvar j = 0; j < OUT_ELEMS; j++)
	begin : g_unpack
		assign cs[0][j] = chan_sum1[(OUT_ELEMS-j)*WCH-1 -: WCH];
		assign cs[1][j] = chan_sum2[(OUT_ELEMS-j)*WCH-1 -: WCH];
	end

	always_ff @(posedge clk)
	begin
		for (int f = 0; f < 2; f++)
			for (int j = 0; j < OUT_ELEMS; j++)
				relu[f][j] <= (cs[f][j] > 0) ? cs[f][j] : '0;
	end

	// first pooling level is combinational
	always_comb
	begin
		for (int f = 0; f < 2; f++)
		begin
			pair_top[f] = smax(relu[f][0], relu[f][1]);
			pair_bot[f] = smax(relu[f][2], relu[f][3]);
		end
	end

	always_ff @(posedge clk)
	begin
		for (int f = 0; f < 2; f++)
			pool_fr[f] <= smax(pair_top[f], pair_bot[f]);
	end

	always_ff @(posedge clk)
	begin
		if (pool_mode_pool == POOL_PER_FRAME)
		begin
			pooled1 <= pool_fr[0];
			pooled2 <= pool_fr[1];
		end
		else
		begin
			pooled1 <= smax(pool_fr[0], pool_fr[1]);	// both frames into one
			pooled2 <= '0;
		end
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			ofmp_frame1 <= '0;
			ofmp_frame2 <= '0;
		end
		else if (out_fix_pool == FIX_SHIFT1)
		begin
			ofmp_frame1 <= pooled1[WCH-2 -: WO];
			ofmp_frame2 <= pooled2[WCH-2 -: WO];
		end
		else
		begin
			ofmp_frame1 <= pooled1[WCH-1 -: WO];
			ofmp_frame2 <= pooled2[WCH-1 -: WO];
		end
	end

	always_comb
	begin
		relu_neg = 1'b0;
		for (int f = 0; f < 2; f++)
			for (int j = 0; j < OUT_ELEMS; j++)
				relu_neg = relu_neg | relu[f][j][WCH-1];
	end

	a_relu_pos: assert property (@(posedge clk) disable iff (!reset) !relu_neg)
		else $error("negative value past the relu stage");

endmodule

// File: hw/winograd_pe_top.sv
`timescale 1ns/1ps

module winograd_pe_top #(
	parameter int WI_T = pe_pkg::DEF_WI_T,
	parameter int WK_T = pe_pkg::DEF_WK_T,
	parameter int WM_O = pe_pkg::DEF_WM_O,
	parameter int WO_T = pe_pkg::DEF_WO_T,
	parameter int WB   = pe_pkg::DEF_WB,
	parameter int WFR  = pe_pkg::DEF_WFR,
	parameter int WCH  = pe_pkg::DEF_WCH,
	parameter int WO   = pe_pkg::DEF_WO
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [pe_pkg::TILE_ELEMS*WI_T-1:0] frame1,
	input  logic [pe_pkg::TILE_ELEMS*WI_T-1:0] frame2,
	input  logic [pe_pkg::TILE_ELEMS*WI_T-1:0] frame3,
	input  logic [pe_pkg::TILE_ELEMS*WI_T-1:0] frame4,
	input  logic [pe_pkg::TILE_ELEMS*WK_T-1:0] weight1,
	input  logic [pe_pkg::TILE_ELEMS*WK_T-1:0] weight2,
	input  logic [pe_pkg::TILE_ELEMS*WK_T-1:0] weight3,
	input  logic                               chan_start,
	input  logic signed [WB-1:0]               conv_bias,
	input  pe_pkg::pool_mode_e                 pool_mode,
	input  pe_pkg::out_fix_e                   out_fix,
	output logic signed [WO-1:0]               ofmp_frame1,
	output logic signed [WO-1:0]               ofmp_frame2
);
	import pe_pkg::*;

	// frame 1 products
	logic [OUT_ELEMS*WO_T-1:0] t_f1w1;
	logic [OUT_ELEMS*WO_T-1:0] t_f2w2;
	logic [OUT_ELEMS*WO_T-1:0] t_f3w3;
	// frame 2 products
	logic [OUT_ELEMS*WO_T-1:0] t_f2w1;
	logic [OUT_ELEMS*WO_T-1:0] t_f3w2;
	logic [OUT_ELEMS*WO_T-1:0] t_f4w3;

	logic [OUT_ELEMS*WCH-1:0]  chan_sum1;
	logic [OUT_ELEMS*WCH-1:0]  chan_sum2;
	logic                      chan_start_acc;
	logic signed [WB-1:0]      bias_acc;
	pool_mode_e                pool_mode_pool;
	out_fix_e                  out_fix_pool;

	winograd_tile_path #(.WI_T(WI_T), .WK_T(WK_T), .WM_O(WM_O), .WO_T(WO_T)) u_tp_f1w1 (
		.clk(clk), .frame(frame1), .weight(weight1), .tile_out(t_f1w1));
	winograd_tile_path #(.WI_T(WI_T), .WK_T(WK_T), .WM_O(WM_O), .WO_T(WO_T)) u_tp_f2w2 (
		.clk(clk), .frame(frame2), .weight(weight2), .tile_out(t_f2w2));
	winograd_tile_path #(.WI_T(WI_T), .WK_T(WK_T), .WM_O(WM_O), .WO_T(WO_T)) u_tp_f3w3 (
		.clk(clk), .frame(frame3), .weight(weight3), .tile_out(t_f3w3));
	winograd_tile_path #(.WI_T(WI_T), .WK_T(WK_T), .WM_O(WM_O), .WO_T(WO_T)) u_tp_f2w1 (
		.clk(clk), .frame(frame2), .weight(weight1), .tile_out(t_f2w1));
	winograd_tile_path #(.WI_T(WI_T), .WK_T(WK_T), .WM_O(WM_O), .WO_T(WO_T)) u_tp_f3w2 (
		.clk(clk), .frame(frame3), .weight(weight2), .tile_out(t_f3w2));
	winograd_tile_path #(.WI_T(WI_T), .WK_T(WK_T), .WM_O(WM_O), .WO_T(WO_T)) u_tp_f4w3 (
		.clk(clk), .frame(frame4), .weight(weight3), .tile_out(t_f4w3));

	control_delay #(.WB(WB)) u_ctrl (
		.clk(clk), .reset(reset), .chan_start(chan_start), .conv_bias(conv_bias),
		.pool_mode(pool_mode), .out_fix(out_fix), .chan_start_acc(chan_start_acc),
		.bias_acc(bias_acc), .pool_mode_pool(pool_mode_pool), .out_fix_pool(out_fix_pool));

	channel_accumulator #(.WO_T(WO_T), .WFR(WFR), .WCH(WCH), .WB(WB)) u_acc1 (
		.clk(clk), .reset(reset), .tile_a(t_f1w1), .tile_b(t_f2w2), .tile_c(t_f3w3),
		.chan_start_acc(chan_start_acc), .bias_acc(bias_acc), .chan_sum(chan_sum1));

	channel_accumulator #(.WO_T(WO_T), .WFR(WFR), .WCH(WCH), .WB(WB)) u_acc2 (
		.clk(clk), .reset(reset), .tile_a(t_f2w1), .tile_b(t_f3w2), .tile_c(t_f4w3),
		.chan_start_acc(chan_start_acc), .bias_acc(bias_acc), .chan_sum(chan_sum2));

	relu_pool_unit #(.WCH(WCH), .WO(WO)) u_pool (
		.clk(clk), .reset(reset), .chan_sum1(chan_sum1), .chan_sum2(chan_sum2),
		.pool_mode_pool(pool_mode_pool), .out_fix_pool(out_fix_pool),
		.ofmp_frame1(ofmp_frame1), .ofmp_frame2(ofmp_frame2));

endmodule

// File: tests/pe_ref_model.svh
`ifndef PE_REF_MODEL_SVH
`define PE_REF_MODEL_SVH

// expected channel sums by [output frame][element]
longint acc_state [2][OUT_ELEMS];

// low w bits of v read back as a signed number
function automatic longint wrap_to(input longint v, input int w);
	longint m;
	m = v & ((64'sd1 << w) - 64'sd1);
	if (m[w-1])
		m = m - (64'sd1 << w);
	return m;
endfunction

// element j of Y = A' (F .* W) A with every stage wrapped at WO_T
function automatic longint tile_ref(input logic [TILE_ELEMS*WI_T-1:0] fr,
		input logic [TILE_ELEMS*WK_T-1:0] wt, input int j);
	longint at_coef [2][4] = '{'{1, 1, 1, 0}, '{0, 1, -1, -1}};
	longint m [TILE_ELEMS];
	longint t [2][4];
	longint s;
	for (int i = 0; i < TILE_ELEMS; i++)
		m[i] = wrap_to(longint'($signed(fr[(TILE_ELEMS-i)*WI_T-1 -: WI_T]))
			* longint'($signed(wt[(TILE_ELEMS-i)*WK_T-1 -: WK_T])), WM_O) >>> (WM_O - WO_T);
	for (int r = 0; r < 2; r++)
		for (int c = 0; c < 4; c++)
		begin
			s = 0;
			for (int k = 0; k < 4; k++)
				s += at_coef[r][k] * m[4*k+c];	// m is row-major
			t[r][c] = wrap_to(s, WO_T);
		end
	s = 0;
	for (int k = 0; k < 4; k++)
		s += t[j/2][k] * at_coef[j%2][k];	// A is the transpose of A'
	return wrap_to(s, WO_T);
endfunction

// 12-bit window of a non-negative channel value
function automatic longint output_cut(input longint v, input out_fix_e fx);
	return (fx == FIX_SHIFT1) ? wrap_to(v >>> 1, WO) : wrap_to(v >>> 2, WO);
endfunction

// one stream input updates acc_state and returns both expected outputs
function automatic void model_step(
		input logic [TILE_ELEMS*WI_T-1:0] f1, f2, f3, f4,
		input logic [TILE_ELEMS*WK_T-1:0] w1, w2, w3,
		input logic start, input logic signed [WB-1:0] bias,
		input pool_mode_e pm, input out_fix_e fx,
		output logic signed [WO-1:0] o1, output logic signed [WO-1:0] o2);
	longint fs;
	longint best [2];
	for (int f = 0; f < 2; f++)
	begin
		best[f] = 0;	// relu floor
		for (int j = 0; j < OUT_ELEMS; j++)
		begin
			if (f == 0)
				fs = tile_ref(f1, w1, j) + tile_ref(f2, w2, j) + tile_ref(f3, w3, j);
			else
				fs = tile_ref(f2, w1, j) + tile_ref(f3, w2, j) + tile_ref(f4, w3, j);
			fs = wrap_to(fs, WFR);
			if (start)
				acc_state[f][j] = wrap_to(fs + longint'(bias), WCH);
			else
				acc_state[f][j] = wrap_to(acc_state[f][j] + fs, WCH);
			if (acc_state[f][j] > best[f])
				best[f] = acc_state[f][j];
		end
	end
	if (pm == POOL_PER_FRAME)
	begin
		o1 = WO'(output_cut(best[0], fx));
		o2 = WO'(output_cut(best[1], fx));
	end
	else
	begin
		o1 = WO'(output_cut((best[0] > best[1]) ? best[0] : best[1], fx));
		o2 = '0;
	end
endfunction

`endif

// File: tests/tb_winograd_pe.sv
`timescale 1ns/1ps

module tb_winograd_pe;
	import pe_pkg::*;

	localparam int WI_T = DEF_WI_T;
	localparam int WK_T = DEF_WK_T;
	localparam int WM_O = DEF_WM_O;
	localparam int WO_T = DEF_WO_T;
	localparam int WB   = DEF_WB;
	localparam int WFR  = DEF_WFR;
	localparam int WCH  = DEF_WCH;
	localparam int WO   = DEF_WO;
	localparam int DRAIN_LIMIT = 4 * PE_LATENCY;	// cycles allowed to empty the queue

	logic clk = 1'b0;
	logic reset;
	logic [TILE_ELEMS*WI_T-1:0] frame1, frame2, frame3, frame4;
	logic [TILE_ELEMS*WK_T-1:0] weight1, weight2, weight3;
	logic chan_start;
	logic signed [WB-1:0] conv_bias;
	pool_mode_e pool_mode;
	out_fix_e out_fix;
	logic signed [WO-1:0] ofmp_frame1;
	logic signed [WO-1:0] ofmp_frame2;

	// next data set, kept so it can be applied twice
	logic [TILE_ELEMS*WI_T-1:0] nf1, nf2, nf3, nf4;
	logic [TILE_ELEMS*WK_T-1:0] nw1, nw2, nw3;
	logic signed [WB-1:0] nbias;

	int seed = 9;
	int cyc;	// rising edges so far
	bit first_done;
	string name_q [$];
	logic signed [WO-1:0] exp1_q [$];
	logic signed [WO-1:0] exp2_q [$];
	int due_q [$];	// edge that registers the result

	`include "pe_ref_model.svh"

	winograd_pe_top #(.WI_T(WI_T), .WK_T(WK_T), .WM_O(WM_O), .WO_T(WO_T), .WB(WB),
		.WFR(WFR), .WCH(WCH), .WO(WO)) DUT (.*);

	always #2 clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1);
	endtask

	function automatic logic [TILE_ELEMS*WI_T-1:0] random_frame();
		logic [TILE_ELEMS*WI_T-1:0] t;
		logic signed [11:0] v;
		for (int i = 0; i < TILE_ELEMS; i++)
		begin
			v = 12'($random(seed));
			t[(TILE_ELEMS-i)*WI_T-1 -: WI_T] = WI_T'(v);	// sign-extended
		end
		return t;
	endfunction

	function automatic logic [TILE_ELEMS*WK_T-1:0] random_weight();
		logic [TILE_ELEMS*WK_T-1:0] t;
		logic signed [8:0] v;
		for (int i = 0; i < TILE_ELEMS; i++)
		begin
			v = 9'($random(seed));
			t[(TILE_ELEMS-i)*WK_T-1 -: WK_T] = WK_T'(v);
		end
		return t;
	endfunction

	task automatic draw_inputs();
		nf1 = random_frame();
		nf2 = random_frame();
		nf3 = random_frame();
		nf4 = random_frame();
		nw1 = random_weight();
		nw2 = random_weight();
		nw3 = random_weight();
		nbias = WB'($random(seed));
	endtask

	// drive one input on the next edge and queue what must come out
	task automatic apply_item(input string name, input logic start, input pool_mode_e pm,
			input out_fix_e fx);
		logic signed [WO-1:0] e1;
		logic signed [WO-1:0] e2;
		@(posedge clk);
		frame1 <= nf1;
		frame2 <= nf2;
		frame3 <= nf3;
		frame4 <= nf4;
		weight1 <= nw1;
		weight2 <= nw2;
		weight3 <= nw3;
		chan_start <= start;
		conv_bias <= nbias;
		pool_mode <= pm;
		out_fix <= fx;
		model_step(nf1, nf2, nf3, nf4, nw1, nw2, nw3, start, nbias, pm, fx, e1, e2);
		name_q.push_back(name);
		exp1_q.push_back(e1);
		exp2_q.push_back(e2);
		due_q.push_back(cyc + PE_LATENCY);
	endtask

	task automatic check_zero(input string name);
		assert (ofmp_frame1 == '0 && ofmp_frame2 == '0)
		else fail_run($sformatf("[ERROR] %s: expected 0/0, got %0d/%0d",
			name, ofmp_frame1, ofmp_frame2));
	endtask

	task automatic check_front();
		assert (ofmp_frame1 == exp1_q[0])
		else fail_run($sformatf("[ERROR] %s frame1: expected %0d, got %0d",
			name_q[0], exp1_q[0], ofmp_frame1));
		assert (ofmp_frame2 == exp2_q[0])
		else fail_run($sformatf("[ERROR] %s frame2: expected %0d, got %0d",
			name_q[0], exp2_q[0], ofmp_frame2));
		void'(name_q.pop_front());
		void'(exp1_q.pop_front());
		void'(exp2_q.pop_front());
		void'(due_q.pop_front());
		first_done = 1'b1;
	endtask

	// outputs sampled halfway between rising edges
	always @(negedge clk)
	begin
		if (!reset)
			check_zero("in_reset");
		else if (due_q.size() > 0 && cyc - 1 == due_q[0])
			check_front();
		else if (!first_done)
			check_zero("after_reset");
	end

	initial
	begin
		logic [31:0] mode_bits;
		reset <= 1'b0;
		frame1 <= '0;
		frame2 <= '0;
		frame3 <= '0;
		frame4 <= '0;
		weight1 <= '0;
		weight2 <= '0;
		weight3 <= '0;
		chan_start <= 1'b0;
		conv_bias <= '0;
		pool_mode <= POOL_ACROSS_FRAMES;
		out_fix <= FIX_SHIFT2;
		repeat (8) @(posedge clk);
		reset <= 1'b1;

		for (int i = 0; i < 3; i++)
		begin
			draw_inputs();
			apply_item("single_channel", 1'b1, POOL_PER_FRAME, FIX_SHIFT1);
		end
		for (int i = 0; i < 8; i++)
		begin
			draw_inputs();
			apply_item("multi_channel", i % 4 == 0, POOL_PER_FRAME, FIX_SHIFT1);	// 4 channels
		end
		for (int i = 0; i < 4; i++)
		begin
			draw_inputs();
			apply_item("across_frames", 1'b1, POOL_ACROSS_FRAMES, FIX_SHIFT1);
		end
		// same data through both output windows
		for (int i = 0; i < 3; i++)
		begin
			draw_inputs();
			apply_item("fix_shift1", 1'b1, POOL_PER_FRAME, FIX_SHIFT1);
			apply_item("fix_shift2", 1'b1, POOL_PER_FRAME, FIX_SHIFT2);
		end
		for (int i = 0; i < 40; i++)
		begin
			draw_inputs();
			mode_bits = $random(seed);
			apply_item("streaming", mode_bits[0], pool_mode_e'(mode_bits[1]),
				out_fix_e'(mode_bits[2]));
		end

		for (int n = 0; n < DRAIN_LIMIT && due_q.size() > 0; n++)
			@(posedge clk);
		if (due_q.size() == 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
			fail_run("outputs were still pending when the drain wait timed out");
	end

endmodule

// File: list.f
+incdir+tests
hw/pe_pkg.sv
hw/winograd_tile_path.sv
hw/control_delay.sv
hw/channel_accumulator.sv
hw/relu_pool_unit.sv
hw/winograd_pe_top.sv
tests/tb_winograd_pe.sv

// File: run.sh
#!/bin/sh
# build and run the PE testbench; the exit status is the verdict
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -j 0 --top-module tb_winograd_pe -f list.f &&
	./obj_dir/Vtb_winograd_pe || exit 1
